// File: Makefile
# Verilator build and run of the CSR unit testbench

TOP = csr_unit_tb

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// File: bench/csr_stimulus.txt
# id cmd addr operand pc exc exc_cause mtime mtimecmp stall | rdata redirect target trap mode
# cmd 0 NONE 1 W 2 S 3 C 4 ECALL 5 MRET 6 SRET, mode 0 U 1 S 3 M, id and stall decimal
 1 1 340 a5a50f0f 00000000 0 00 0000 1000 0 00000000 0 00000000 0 3
 2 2 340 0000f0f0 00000000 0 00 0000 1000 0 a5a50f0f 0 00000000 0 3
 3 3 340 a5a50000 00000000 0 00 0000 1000 0 a5a5ffff 0 00000000 0 3
 4 0 340 00000000 00000000 0 00 0000 1000 0 0000ffff 0 00000000 0 3
 5 1 300 00000020 00000000 0 00 0000 1000 0 00000000 0 00000000 0 3
 6 1 341 00001000 00000000 0 00 0000 1000 0 00000000 0 00000000 0 3
 7 1 305 00000100 00000000 0 00 0000 1000 0 00000000 0 00000000 0 3
 8 5 000 00000000 00000000 0 00 0000 1000 0 00000000 1 00001000 0 0
 9 0 300 00000000 00000000 0 00 0000 1000 0 00000000 0 00000000 0 0
10 1 300 ffffffff 00000000 0 00 0000 1000 0 00000000 0 00000000 0 0
11 4 000 00000000 00002000 0 00 0000 1000 0 00000000 1 00000100 1 3
12 0 342 00000000 00000000 0 00 0000 1000 0 00000008 0 00000000 0 3
13 0 341 00000000 00000000 0 00 0000 1000 0 00002000 0 00000000 0 3
14 0 300 00000000 00000000 0 00 0000 1000 0 00000020 0 00000000 0 3
15 1 302 00000100 00000000 0 00 0000 1000 0 00000000 0 00000000 0 3
16 1 105 00000200 00000000 0 00 0000 1000 0 00000000 0 00000000 0 3
17 5 000 00000000 00000000 0 00 0000 1000 0 00000000 1 00002000 0 0
18 4 000 00000000 00003000 0 00 0000 1000 0 00000000 1 00000200 1 1
19 0 142 00000000 00000000 0 00 0000 1000 0 00000008 0 00000000 0 1
20 0 141 00000000 00000000 0 00 0000 1000 0 00003000 0 00000000 0 1
21 6 000 00000000 00000000 0 00 0000 1000 0 00000000 1 00003000 0 0
22 0 000 00000000 00004000 1 02 0000 1000 0 00000000 1 00000100 1 3
23 1 305 00000101 00000000 0 00 0000 1000 0 00000100 0 00000000 0 3
24 1 304 00000080 00000000 0 00 0000 1000 0 00000000 0 00000000 0 3
25 1 300 00000008 00000000 0 00 0000 1000 0 00000020 0 00000000 0 3
26 0 340 00000000 00000000 0 00 2000 1000 0 0000ffff 0 00000000 0 3
27 0 340 00000000 00005000 0 00 2000 1000 0 00000000 1 0000011c 1 3
28 0 342 00000000 00000000 0 00 0000 1000 0 80000007 0 00000000 0 3
29 1 340 12345678 00000000 0 00 0000 1000 5 0000ffff 0 00000000 0 3
30 0 340 00000000 00000000 0 00 0000 1000 0 12345678 0 00000000 0 3

// File: bench/csr_unit_props.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_props (
    input wire                     clk,
    input wire                     rst_n_i,
    input wire                     req_ready_o,
    input wire                     resp_valid_o,
    input wire                     resp_ready_i,
    input wire csr_pkg::csr_resp_t resp_o
);

    // Response is frozen until the handshake
    resp_held_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (resp_valid_o && !resp_ready_i) |=> $stable(resp_o))
        else $error("resp_o changed while waiting for resp_ready_i");

    // Next request only after the previous response handshake
    one_in_flight_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(req_ready_o) |-> $past(resp_valid_o && resp_ready_i))
        else $error("req_ready_o rose without a response handshake");

    reset_state_a: assert property (@(posedge clk)
        !rst_n_i |=> !resp_valid_o)
        else $error("resp_valid_o high right after reset");

endmodule

bind csr_unit csr_unit_props props0 (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_o       (resp_o)
);

`default_nettype wire

// File: bench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam string STIM_FILE = "bench/csr_stimulus.txt";

    // One transaction from the stimulus file
    typedef struct packed {
        int                      id;
        csr_req_t                req;
        logic [`CSR_TIMER_W-1:0] mtime;
        logic [`CSR_TIMER_W-1:0] mtimecmp;
        logic [7:0]              stall;
        csr_resp_t               resp;
        priv_mode_e              mode;
    } stim_t;

    logic                    clk;
    logic                    rst_n_i;
    logic                    req_valid_i;
    logic                    req_ready_o;
    csr_req_t                req_i;
    logic                    resp_valid_o;
    logic                    resp_ready_i;
    csr_resp_t               resp_o;
    logic [`CSR_TIMER_W-1:0] mtime_i;
    logic [`CSR_TIMER_W-1:0] mtimecmp_i;
    priv_mode_e              mode_o;

    stim_t stim_q[$];
    int    fail_count = 0;
    int    cycles = 0;
    int    cycle_limit = 50;

    csr_unit dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o),
        .mtime_i      (mtime_i),
        .mtimecmp_i   (mtimecmp_i),
        .mode_o       (mode_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_resp(input int id, input csr_resp_t got, input csr_resp_t exp,
                              input string what);
        if (got !== exp) begin
            $display("[FAIL] t=%0t test %0d %s: got %h/%b/%h/%b, expected %h/%b/%h/%b",
                     $time, id, what, got.rdata, got.redirect, got.target, got.trap_taken,
                     exp.rdata, exp.redirect, exp.target, exp.trap_taken);
            fail_count++;
        end
    endtask

    task automatic check_mode(input int id, input priv_mode_e got, input priv_mode_e exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t test %0d: mode %0d, expected %0d", $time, id, got, exp);
            fail_count++;
        end
    endtask

    task automatic check_flag(input int id, input logic got, input logic exp,
                              input string what);
        if (got !== exp) begin
            $display("[FAIL] t=%0t test %0d: %s is %b, expected %b", $time, id, what, got, exp);
            fail_count++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          id;
        int          cmd;
        int          exc_v;
        int          stall;
        int          redir;
        int          trap;
        int          mode;
        logic [31:0] addr;
        logic [31:0] operand;
        logic [31:0] pc;
        logic [31:0] cause;
        logic [31:0] rdata;
        logic [31:0] target;
        logic [63:0] mtime;
        logic [63:0] mtimecmp;
        string       line;
        stim_t       s;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            fail_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %d %h %h %h %h %h",
                        id, cmd, addr, operand, pc, exc_v, cause, mtime, mtimecmp,
                        stall, rdata, redir, target, trap, mode);
            if (n == 15) begin
                s                    = '0;
                s.id                 = id;
                s.req.cmd            = csr_cmd_e'(cmd[2:0]);
                s.req.addr.raw       = addr[11:0];
                s.req.operand        = operand;
                s.req.pc             = pc;
                s.req.exc_valid      = exc_v[0];
                s.req.exc_cause      = cause;
                s.mtime              = mtime;
                s.mtimecmp           = mtimecmp;
                s.stall              = 8'(stall);
                s.resp.rdata         = rdata;
                s.resp.redirect      = redir[0];
                s.resp.target        = target;
                s.resp.trap_taken    = trap[0];
                s.mode               = priv_mode_e'(mode[1:0]);
                stim_q.push_back(s);
            end else if (n > 0) begin
                $display("Malformed line in the stimulus file: %s", line);
                fail_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_request(input stim_t s);
        csr_req_t req;
        req = s.req;
        // Operand is ignored on NONE
        if (req.cmd == CMD_NONE) begin
            req.operand = $urandom;
        end
        while (!req_ready_o) begin
            @(posedge clk);
            #2;
        end
        req_i       = req;
        mtime_i     = s.mtime;
        mtimecmp_i  = s.mtimecmp;
        req_valid_i = 1'b1;
        @(posedge clk);
        #2;
        req_valid_i = 1'b0;
        req_i       = '0;
    endtask

    task automatic collect_response(input stim_t s);
        csr_resp_t held;
        while (!resp_valid_o) begin
            @(posedge clk);
            #2;
        end
        held = resp_o;
        // Nothing may move under back-pressure
        repeat (int'(s.stall)) begin
            @(posedge clk);
            #2;
            check_resp(s.id, resp_o, held, "held response");
            check_flag(s.id, resp_valid_o, 1'b1, "resp_valid_o while held");
            check_flag(s.id, req_ready_o, 1'b0, "req_ready_o while held");
        end
        check_resp(s.id, resp_o, s.resp, "response");
        check_mode(s.id, mode_o, s.mode);
        resp_ready_i = 1'b1;
        @(posedge clk);
        #2;
        resp_ready_i = 1'b0;
        check_flag(s.id, resp_valid_o, 1'b0, "resp_valid_o after handshake");
    endtask

    initial begin
        int errs_before;
        int passed;
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;
        mtime_i      = '0;
        mtimecmp_i   = '1;
        passed       = 0;
        void'($urandom(65));
        load_stimulus();
        cycle_limit = 20 * stim_q.size() + 50;
        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        check_flag(0, req_ready_o, 1'b1, "req_ready_o after reset");
        check_mode(0, mode_o, PRIV_M);
        foreach (stim_q[i]) begin
            errs_before = fail_count;
            drive_request(stim_q[i]);
            collect_response(stim_q[i]);
            if (fail_count == errs_before) begin
                passed++;
                $display("test %0d: ok", stim_q[i].id);
            end else begin
                $display("test %0d: %0d errors", stim_q[i].id, fail_count - errs_before);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors in total",
                 stim_q.size(), passed, stim_q.size() - passed, fail_count);
        if (fail_count == 0 && stim_q.size() > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_access (
    input  wire csr_pkg::csr_state_t  state_i,
    input  wire csr_pkg::csr_req_t    req_i,
    output logic [`CSR_XLEN-1:0]      rdata_o,
    output logic [`CSR_XLEN-1:0]      wdata_o,
    output logic                      wr_req_o
);
    import csr_pkg::*;

    logic                 allowed;
    logic                 is_wr_cmd;
    logic [`CSR_XLEN-1:0] mstatus_w;
    logic [`CSR_XLEN-1:0] sstatus_w;
    logic [`CSR_XLEN-1:0] rd_raw;

    // Same bit layout for mie/mip and their S views
    function automatic logic [`CSR_XLEN-1:0] irq_word(irq_bits_t b, logic with_m);
        logic [`CSR_XLEN-1:0] w;
        w    = '0;
        w[9] = b.sei;
        w[7] = b.mti & with_m;
        w[5] = b.sti;
        w[1] = b.ssi;
        return w;
    endfunction

    always_comb begin
        mstatus_w        = '0;
        mstatus_w[12:11] = state_i.mstatus_mpp;
        mstatus_w[8]     = state_i.mstatus_spp;
        mstatus_w[7]     = state_i.mstatus_mpie;
        mstatus_w[5]     = state_i.mstatus_spie;
        mstatus_w[3]     = state_i.mstatus_mie;
        mstatus_w[1]     = state_i.mstatus_sie;
        sstatus_w        = '0;
        sstatus_w[8]     = state_i.mstatus_spp;
        sstatus_w[5]     = state_i.mstatus_spie;
        sstatus_w[1]     = state_i.mstatus_sie;
    end

    always_comb begin
        case (req_i.addr.raw)
            ADDR_MSTATUS:  rd_raw = mstatus_w;
            ADDR_SSTATUS:  rd_raw = sstatus_w;
            ADDR_MISA:     rd_raw = `CSR_MISA_VALUE;
            ADDR_MEDELEG:  rd_raw = state_i.medeleg;
            ADDR_MIDELEG:  rd_raw = state_i.mideleg;
            ADDR_MIE:      rd_raw = irq_word(state_i.mie, 1'b1);
            ADDR_SIE:      rd_raw = irq_word(state_i.mie, 1'b0);
            ADDR_MIP:      rd_raw = irq_word(state_i.mip, 1'b1);
            ADDR_SIP:      rd_raw = irq_word(state_i.mip, 1'b0);
            ADDR_MTVEC:    rd_raw = state_i.mtvec;
            ADDR_STVEC:    rd_raw = state_i.stvec;
            ADDR_MEPC:     rd_raw = state_i.mepc;
            ADDR_SEPC:     rd_raw = state_i.sepc;
            ADDR_MCAUSE:   rd_raw = state_i.mcause;
            ADDR_SCAUSE:   rd_raw = state_i.scause;
            ADDR_MSCRATCH: rd_raw = state_i.mscratch;
            ADDR_SSCRATCH: rd_raw = state_i.sscratch;
            default:       rd_raw = '0;
        endcase
    end

    // Address bits 9:8 give the lowest mode allowed
    assign allowed   = (req_i.addr.f.priv <= state_i.mode);
    assign rdata_o   = allowed ? rd_raw : '0;
    assign is_wr_cmd = req_i.cmd inside {CMD_W, CMD_S, CMD_C};
    assign wr_req_o  = is_wr_cmd && allowed && (req_i.addr.f.ro != 2'b11);

    always_comb begin
        case (req_i.cmd)
            CMD_W:   wdata_o = req_i.operand;
            CMD_S:   wdata_o = rdata_o | req_i.operand;
            CMD_C:   wdata_o = rdata_o & ~req_i.operand;
            default: wdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Data, address and timer widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_TIMER_W         64

// MXL=1 with the A, I and M extensions
`define CSR_MISA_VALUE      32'h4000_1101

// Exception causes
`define CSR_CAUSE_ILLEGAL   32'd2
`define CSR_CAUSE_ECALL_U   32'd8
`define CSR_CAUSE_INT_BIT   31

// Interrupt codes
`define CSR_CAUSE_SSI       5'd1
`define CSR_CAUSE_STI       5'd5
`define CSR_CAUSE_MTI       5'd7
`define CSR_CAUSE_SEI       5'd9

// Interrupts that may be handed to S mode
`define CSR_MIDELEG_MASK    32'h0000_0222

`endif

// File: rtl/csr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_ctrl (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       req_valid_i,
    output logic                      req_ready_o,
    input  wire csr_pkg::csr_req_t    req_i,
    output logic                      resp_valid_o,
    input  wire                       resp_ready_i,
    output csr_pkg::csr_resp_t        resp_o,
    output csr_pkg::csr_req_t         cur_req_o,
    input  wire csr_pkg::trap_info_t  trap_i,
    input  wire                       wr_req_i,
    input  wire [`CSR_XLEN-1:0]       rdata_i,
    output csr_pkg::csr_action_t      action_o
);
    import csr_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_RESP
    } ctrl_state_e;

    ctrl_state_e state_q;
    csr_req_t    req_q;
    csr_resp_t   resp_q;
    logic        take_trap;
    logic        is_xret;
    logic        redirect;

    assign req_ready_o  = (state_q == ST_IDLE);
    assign resp_valid_o = (state_q == ST_RESP);
    assign resp_o       = resp_q;
    assign cur_req_o    = req_q;

    // Exceptions and ECALL win over everything else
    assign take_trap = req_q.exc_valid || (req_q.cmd == CMD_ECALL) || trap_i.irq;
    assign is_xret   = (req_q.cmd == CMD_MRET) || (req_q.cmd == CMD_SRET);
    assign redirect  = take_trap || is_xret;

    // Strobes only fire in EXEC, so a held response changes nothing
    always_comb begin
        action_o = '0;
        if (state_q == ST_EXEC) begin
            action_o.trap = take_trap;
            action_o.mret = !take_trap && (req_q.cmd == CMD_MRET);
            action_o.sret = !take_trap && (req_q.cmd == CMD_SRET);
            action_o.wr   = !take_trap && wr_req_i;
            action_o.done = !take_trap && !is_xret && !wr_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (req_valid_i) state_q <= ST_EXEC;
                ST_EXEC: state_q <= ST_RESP;
                ST_RESP: if (resp_ready_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            req_q <= req_i;
        end
        // Captured on the same edge as the state update
        if (state_q == ST_EXEC) begin
            resp_q.rdata      <= redirect ? '0 : rdata_i;
            resp_q.redirect   <= redirect;
            resp_q.target     <= redirect ? trap_i.vector : '0;
            resp_q.trap_taken <= take_trap;
        end
    end

endmodule

`default_nettype wire

// File: rtl/csr_pkg.sv
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5,
        CMD_SRET  = 3'd6
    } csr_cmd_e;

    // Implemented CSR addresses
    localparam logic [`CSR_ADDR_W-1:0] ADDR_SSTATUS  = 12'h100;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_SIE      = 12'h104;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_STVEC    = 12'h105;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_SSCRATCH = 12'h140;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_SEPC     = 12'h141;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_SCAUSE   = 12'h142;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_SIP      = 12'h144;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MISA     = 12'h301;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MEDELEG  = 12'h302;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MIDELEG  = 12'h303;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_MIP      = 12'h344;

    // Address convention fields
    typedef struct packed {
        logic [1:0] ro;
        logic [1:0] priv;
        logic [7:0] index;
    } csr_addr_fields_t;

    typedef union packed {
        logic [`CSR_ADDR_W-1:0] raw;
        csr_addr_fields_t       f;
    } csr_addr_u;

    typedef struct packed {
        csr_cmd_e             cmd;
        csr_addr_u            addr;
        logic [`CSR_XLEN-1:0] operand;
        logic [`CSR_XLEN-1:0] pc;
        logic                 exc_valid;
        logic [`CSR_XLEN-1:0] exc_cause;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] rdata;
        logic                 redirect;
        logic [`CSR_XLEN-1:0] target;
        logic                 trap_taken;
    } csr_resp_t;

    typedef struct packed {
        logic wr;
        logic trap;
        logic mret;
        logic sret;
        logic done;
    } csr_action_t;

    // Interrupt source bits shared by mie and mip
    typedef struct packed {
        logic mti;
        logic sei;
        logic ssi;
        logic sti;
    } irq_bits_t;

    typedef struct packed {
        priv_mode_e           mode;
        logic                 mstatus_mie;
        logic                 mstatus_sie;
        logic                 mstatus_mpie;
        logic                 mstatus_spie;
        priv_mode_e           mstatus_mpp;
        logic                 mstatus_spp;
        irq_bits_t            mie;
        irq_bits_t            mip;
        logic [`CSR_XLEN-1:0] medeleg;
        logic [`CSR_XLEN-1:0] mideleg;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] stvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] sepc;
        logic [`CSR_XLEN-1:0] mcause;
        logic [`CSR_XLEN-1:0] scause;
        logic [`CSR_XLEN-1:0] mscratch;
        logic [`CSR_XLEN-1:0] sscratch;
    } csr_state_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] cause;
        logic                 to_m;
        logic [`CSR_XLEN-1:0] vector;
        logic                 irq;
    } trap_info_t;

endpackage

`default_nettype wire

// File: rtl/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_regfile (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire csr_pkg::csr_action_t   action_i,
    input  wire csr_pkg::csr_req_t      req_i,
    input  wire csr_pkg::trap_info_t    trap_i,
    input  wire [`CSR_XLEN-1:0]         wdata_i,
    input  wire [`CSR_TIMER_W-1:0]      mtime_i,
    input  wire [`CSR_TIMER_W-1:0]      mtimecmp_i,
    output csr_pkg::csr_state_t         state_o,
    output csr_pkg::priv_mode_e         mode_o
);
    import csr_pkg::*;

    csr_state_t st_q;
    logic       timer_hit;
    logic       non_trap;

    assign timer_hit = (mtime_i >= mtimecmp_i);
    assign non_trap  = action_i.wr || action_i.mret || action_i.sret || action_i.done;
    assign state_o   = st_q;
    assign mode_o    = st_q.mode;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            st_q      <= '0;
            st_q.mode <= PRIV_M;
        end else if (action_i.trap) begin
            if (trap_i.to_m) begin
                st_q.mode         <= PRIV_M;
                st_q.mcause       <= trap_i.cause;
                st_q.mepc         <= req_i.pc;
                st_q.mstatus_mpie <= st_q.mstatus_mie;
                st_q.mstatus_mie  <= 1'b0;
                st_q.mstatus_mpp  <= st_q.mode;
            end else begin
                st_q.mode         <= PRIV_S;
                st_q.scause       <= trap_i.cause;
                st_q.sepc         <= req_i.pc;
                st_q.mstatus_spie <= st_q.mstatus_sie;
                st_q.mstatus_sie  <= 1'b0;
                st_q.mstatus_spp  <= st_q.mode[0];
            end
            // Served interrupt drops out of mip
            if (trap_i.cause[`CSR_CAUSE_INT_BIT]) begin
                case (trap_i.cause[4:0])
                    `CSR_CAUSE_MTI: st_q.mip.mti <= 1'b0;
                    `CSR_CAUSE_SEI: st_q.mip.sei <= 1'b0;
                    `CSR_CAUSE_SSI: st_q.mip.ssi <= 1'b0;
                    `CSR_CAUSE_STI: st_q.mip.sti <= 1'b0;
                    default: begin
                    end
                endcase
            end
        end else begin
            if (non_trap) begin
                st_q.mip.mti <= timer_hit;
            end
            if (action_i.mret) begin
                st_q.mstatus_mie  <= st_q.mstatus_mpie;
                st_q.mstatus_mpie <= 1'b1;
                st_q.mode         <= st_q.mstatus_mpp;
                st_q.mstatus_mpp  <= PRIV_U;
            end
            if (action_i.sret) begin
                st_q.mstatus_sie  <= st_q.mstatus_spie;
                st_q.mstatus_spie <= 1'b1;
                st_q.mode         <= st_q.mstatus_spp ? PRIV_S : PRIV_U;
                st_q.mstatus_spp  <= 1'b0;
            end
            if (action_i.wr) begin
                case (req_i.addr.raw)
                    ADDR_MSTATUS: begin
                        // Reserved mode 2 falls back to U
                        st_q.mstatus_mpp  <= (wdata_i[12:11] == 2'b10) ? PRIV_U
                                             : priv_mode_e'(wdata_i[12:11]);
                        st_q.mstatus_spp  <= wdata_i[8];
                        st_q.mstatus_mpie <= wdata_i[7];
                        st_q.mstatus_spie <= wdata_i[5];
                        st_q.mstatus_mie  <= wdata_i[3];
                        st_q.mstatus_sie  <= wdata_i[1];
                    end
                    ADDR_SSTATUS: begin
                        st_q.mstatus_spp  <= wdata_i[8];
                        st_q.mstatus_spie <= wdata_i[5];
                        st_q.mstatus_sie  <= wdata_i[1];
                    end
                    ADDR_MEDELEG:  st_q.medeleg <= {16'b0, wdata_i[15:0]};
                    ADDR_MIDELEG:  st_q.mideleg <= wdata_i & `CSR_MIDELEG_MASK;
                    ADDR_MIE: begin
                        st_q.mie.sei <= wdata_i[9];
                        st_q.mie.mti <= wdata_i[7];
                        st_q.mie.sti <= wdata_i[5];
                        st_q.mie.ssi <= wdata_i[1];
                    end
                    ADDR_SIE: begin
                        st_q.mie.sei <= wdata_i[9];
                        st_q.mie.sti <= wdata_i[5];
                        st_q.mie.ssi <= wdata_i[1];
                    end
                    // MTI pending follows the timer only
                    ADDR_MIP: begin
                        st_q.mip.sei <= wdata_i[9];
                        st_q.mip.sti <= wdata_i[5];
                        st_q.mip.ssi <= wdata_i[1];
                    end
                    ADDR_SIP:      st_q.mip.ssi  <= wdata_i[1];
                    ADDR_MTVEC:    st_q.mtvec    <= wdata_i;
                    ADDR_STVEC:    st_q.stvec    <= wdata_i;
                    ADDR_MEPC:     st_q.mepc     <= {wdata_i[`CSR_XLEN-1:2], 2'b00};
                    ADDR_SEPC:     st_q.sepc     <= {wdata_i[`CSR_XLEN-1:2], 2'b00};
                    ADDR_MCAUSE:   st_q.mcause   <= wdata_i;
                    ADDR_SCAUSE:   st_q.scause   <= wdata_i;
                    ADDR_MSCRATCH: st_q.mscratch <= wdata_i;
                    ADDR_SSCRATCH: st_q.sscratch <= wdata_i;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/csr_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_trap_unit (
    input  wire csr_pkg::csr_state_t  state_i,
    input  wire csr_pkg::csr_req_t    req_i,
    output csr_pkg::trap_info_t       trap_o
);
    import csr_pkg::*;

    irq_bits_t            pend;
    logic [4:0]           irq_code;
    logic                 irq_to_m;
    logic                 global_mie;
    logic                 global_sie;
    logic                 irq_take;
    logic                 is_exc;
    logic [`CSR_XLEN-1:0] exc_cause;
    logic [`CSR_XLEN-1:0] irq_cause;
    logic [`CSR_XLEN-1:0] tvec;

    assign pend = state_i.mip & state_i.mie;

    // Fixed priority MTI > SEI > SSI > STI
    always_comb begin
        if (pend.mti)      irq_code = `CSR_CAUSE_MTI;
        else if (pend.sei) irq_code = `CSR_CAUSE_SEI;
        else if (pend.ssi) irq_code = `CSR_CAUSE_SSI;
        else               irq_code = `CSR_CAUSE_STI;
    end

    // Global enables depend on where the interrupt lands
    assign global_mie = (state_i.mode == PRIV_M) ? state_i.mstatus_mie : 1'b1;
    assign global_sie = (state_i.mode == PRIV_S) ? state_i.mstatus_sie
                                                 : (state_i.mode == PRIV_U);
    assign irq_to_m   = !state_i.mideleg[irq_code];
    assign irq_take   = (|pend) && (irq_to_m ? global_mie : global_sie);

    assign is_exc    = req_i.exc_valid || (req_i.cmd == CMD_ECALL);
    assign exc_cause = req_i.exc_valid ? req_i.exc_cause
                                       : `CSR_CAUSE_ECALL_U + {30'b0, state_i.mode};

    always_comb begin
        irq_cause                     = `CSR_XLEN'(irq_code);
        irq_cause[`CSR_CAUSE_INT_BIT] = 1'b1;
    end

    always_comb begin
        trap_o.irq   = irq_take;
        trap_o.cause = is_exc ? exc_cause : irq_cause;
        if (state_i.mode == PRIV_M) begin
            trap_o.to_m = 1'b1;
        end else if (is_exc) begin
            trap_o.to_m = !state_i.medeleg[exc_cause[4:0]];
        end else begin
            trap_o.to_m = irq_to_m;
        end
        tvec          = trap_o.to_m ? state_i.mtvec : state_i.stvec;
        trap_o.vector = {tvec[`CSR_XLEN-1:2], 2'b00};
        // Vectored mode only offsets interrupts
        if (tvec[1:0] == 2'b01 && !is_exc) begin
            trap_o.vector = {tvec[`CSR_XLEN-1:2], 2'b00} + `CSR_XLEN'({irq_code, 2'b00});
        end
        // Without a trap, the target is the return address
        if (!is_exc && !irq_take) begin
            if (req_i.cmd == CMD_MRET) begin
                trap_o.vector = state_i.mepc;
            end else if (req_i.cmd == CMD_SRET) begin
                trap_o.vector = state_i.sepc;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_unit (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        req_valid_i,
    output logic                       req_ready_o,
    input  wire csr_pkg::csr_req_t     req_i,
    output logic                       resp_valid_o,
    input  wire                        resp_ready_i,
    output csr_pkg::csr_resp_t         resp_o,
    input  wire [`CSR_TIMER_W-1:0]     mtime_i,
    input  wire [`CSR_TIMER_W-1:0]     mtimecmp_i,
    output csr_pkg::priv_mode_e        mode_o
);
    import csr_pkg::*;

    csr_req_t             cur_req;
    trap_info_t           trap;
    csr_action_t          action;
    csr_state_t           state;
    logic                 wr_req;
    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] wdata;

    csr_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o),
        .cur_req_o    (cur_req),
        .trap_i       (trap),
        .wr_req_i     (wr_req),
        .rdata_i      (rdata),
        .action_o     (action)
    );

    csr_access u_access (
        .state_i  (state),
        .req_i    (cur_req),
        .rdata_o  (rdata),
        .wdata_o  (wdata),
        .wr_req_o (wr_req)
    );

    csr_trap_unit u_trap (
        .state_i (state),
        .req_i   (cur_req),
        .trap_o  (trap)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .action_i   (action),
        .req_i      (cur_req),
        .trap_i     (trap),
        .wdata_i    (wdata),
        .mtime_i    (mtime_i),
        .mtimecmp_i (mtimecmp_i),
        .state_o    (state),
        .mode_o     (mode_o)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_ctrl.sv
rtl/csr_access.sv
rtl/csr_trap_unit.sv
rtl/csr_regfile.sv
rtl/csr_unit.sv
bench/csr_unit_props.sv
bench/csr_unit_tb.sv
